/* common/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

  // major opcodes, instruction[6:0]
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // load and store widths
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // alu functions, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // selects SUB and SRA
  localparam logic [6:0] F7_ALT = 7'b0100000;

  localparam logic [31:0] EBREAK = 32'h0010_0073;
  // addi x0, x0, 0
  localparam logic [31:0] NOP    = 32'h0000_0013;

endpackage

`default_nettype wire

/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam int XLEN = 32;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_cmd;

  typedef enum logic [3:0] {
    MEM_NONE,
    MEM_LOAD_B,
    MEM_LOAD_H,
    MEM_LOAD_W,
    MEM_LOAD_BU,
    MEM_LOAD_HU,
    MEM_STORE_B,
    MEM_STORE_H,
    MEM_STORE_W
  } mem_access_type;

  // source of the register write value
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel;

  typedef enum logic [1:0] {
    PC_SEQ,
    PC_BRANCH,
    PC_JUMP
  } next_pc_sel;

endpackage

`default_nettype wire

/* cpu/decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module decoder (
  input  logic [31:0]                  instruction,
  input  logic [cpu_pkg::XLEN-1:0]     pc,
  input  logic [cpu_pkg::XLEN-1:0]     regfile [0:31],
  output logic [cpu_pkg::XLEN-1:0]     op1,
  output logic [cpu_pkg::XLEN-1:0]     op2,
  output cpu_pkg::alu_cmd              alu_ops,
  output cpu_pkg::mem_access_type      access_type,
  output cpu_pkg::wb_sel               wb_sel,
  output cpu_pkg::next_pc_sel          pc_sel,
  output logic                         branch_taken,
  output logic [4:0]                   rd,
  output logic [cpu_pkg::XLEN-1:0]     rs2_data,
  output logic [cpu_pkg::XLEN-1:0]     imm
);
  import riscv_pkg::*;
  import cpu_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic       alt;
  logic       writes_rd;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  function automatic alu_cmd alu_for(input logic [2:0] f3, input logic alt_bit,
                                     input logic reg_op);
    alu_cmd cmd;
    case (f3)
      F3_ADD:  cmd = (reg_op && alt_bit) ? ALU_SUB : ALU_ADD;
      F3_SLL:  cmd = ALU_SLL;
      F3_SLT:  cmd = ALU_SLT;
      F3_SLTU: cmd = ALU_SLTU;
      F3_XOR:  cmd = ALU_XOR;
      F3_SRL:  cmd = alt_bit ? ALU_SRA : ALU_SRL;
      F3_OR:   cmd = ALU_OR;
      default: cmd = ALU_AND;
    endcase
    return cmd;
  endfunction

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];
  assign rs1    = instruction[19:15];
  assign rs2    = instruction[24:20];
  assign alt    = (funct7 == F7_ALT);

  assign rs1_data = regfile[rs1];
  assign rs2_data = regfile[rs2];

  assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
  assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                  instruction[30:25], instruction[11:8], 1'b0};
  assign imm_u = {instruction[31:12], 12'b0};
  assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                  instruction[20], instruction[30:21], 1'b0};

  // rd reads as zero for anything that does not write a register
  assign rd = writes_rd ? instruction[11:7] : 5'd0;

  always_comb begin
    op1         = rs1_data;
    op2         = rs2_data;
    imm         = imm_i;
    alu_ops     = ALU_ADD;
    access_type = MEM_NONE;
    wb_sel      = WB_ALU;
    pc_sel      = PC_SEQ;
    writes_rd   = 1'b0;
    case (opcode)
      OPC_LUI: begin
        op2       = imm_u;
        imm       = imm_u;
        alu_ops   = ALU_PASS_B;
        writes_rd = 1'b1;
      end
      OPC_AUIPC: begin
        op1       = pc;
        op2       = imm_u;
        imm       = imm_u;
        writes_rd = 1'b1;
      end
      OPC_JAL: begin
        // target computed by the alu as pc + imm
        op1       = pc;
        op2       = imm_j;
        imm       = imm_j;
        pc_sel    = PC_JUMP;
        wb_sel    = WB_PC4;
        writes_rd = 1'b1;
      end
      OPC_JALR: begin
        op2       = imm_i;
        pc_sel    = PC_JUMP;
        wb_sel    = WB_PC4;
        writes_rd = 1'b1;
      end
      OPC_BRANCH: begin
        imm    = imm_b;
        pc_sel = PC_BRANCH;
      end
      OPC_LOAD: begin
        op2       = imm_i;
        wb_sel    = WB_MEM;
        writes_rd = 1'b1;
        case (funct3)
          F3_B:    access_type = MEM_LOAD_B;
          F3_H:    access_type = MEM_LOAD_H;
          F3_W:    access_type = MEM_LOAD_W;
          F3_BU:   access_type = MEM_LOAD_BU;
          F3_HU:   access_type = MEM_LOAD_HU;
          default: access_type = MEM_NONE;
        endcase
      end
      OPC_STORE: begin
        op2 = imm_s;
        imm = imm_s;
        case (funct3)
          F3_B:    access_type = MEM_STORE_B;
          F3_H:    access_type = MEM_STORE_H;
          F3_W:    access_type = MEM_STORE_W;
          default: access_type = MEM_NONE;
        endcase
      end
      OPC_OP_IMM: begin
        op2       = imm_i;
        alu_ops   = alu_for(funct3, alt, 1'b0);
        writes_rd = 1'b1;
      end
      OPC_OP: begin
        alu_ops   = alu_for(funct3, alt, 1'b1);
        writes_rd = 1'b1;
      end
      // SYSTEM and unknown opcodes have no architectural effect here
      default: begin
        writes_rd = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (funct3)
      F3_BEQ:  branch_taken = (rs1_data == rs2_data);
      F3_BNE:  branch_taken = (rs1_data != rs2_data);
      F3_BLT:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: branch_taken = (rs1_data < rs2_data);
      F3_BGEU: branch_taken = (rs1_data >= rs2_data);
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* cpu/execute.sv */
`timescale 1ns/10ps
`default_nettype none

module execute (
  input  logic [cpu_pkg::XLEN-1:0] op1,
  input  logic [cpu_pkg::XLEN-1:0] op2,
  input  cpu_pkg::alu_cmd          alu_ops,
  output logic [cpu_pkg::XLEN-1:0] alu_out
);
  import cpu_pkg::*;

  logic [4:0] shamt;

  assign shamt = op2[4:0];

  always_comb begin
    case (alu_ops)
      ALU_ADD:    alu_out = op1 + op2;
      ALU_SUB:    alu_out = op1 - op2;
      ALU_SLL:    alu_out = op1 << shamt;
      ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, op1 < op2};
      ALU_XOR:    alu_out = op1 ^ op2;
      ALU_SRL:    alu_out = op1 >> shamt;
      ALU_SRA:    alu_out = $unsigned($signed(op1) >>> shamt);
      ALU_OR:     alu_out = op1 | op2;
      ALU_AND:    alu_out = op1 & op2;
      ALU_PASS_B: alu_out = op2;
      default:    alu_out = '0;
    endcase
  end

endmodule

`default_nettype wire

/* cpu/memory_access.sv */
`timescale 1ns/10ps
`default_nettype none

module memory_access (
  input  cpu_pkg::mem_access_type  access_type,
  output logic [1:0]               write_wstrb,
  output logic                     write_enable,
  output logic                     read_enable,
  output logic [cpu_pkg::XLEN-1:0] wb_mask,
  output logic                     load_signed
);
  import cpu_pkg::*;

  always_comb begin
    write_wstrb  = 2'd0;
    write_enable = 1'b0;
    read_enable  = 1'b0;
    wb_mask      = '0;
    load_signed  = 1'b0;
    case (access_type)
      MEM_LOAD_B: begin
        read_enable = 1'b1;
        wb_mask     = XLEN'(32'h0000_00ff);
        load_signed = 1'b1;
      end
      MEM_LOAD_BU: begin
        read_enable = 1'b1;
        wb_mask     = XLEN'(32'h0000_00ff);
      end
      MEM_LOAD_H: begin
        read_enable = 1'b1;
        wb_mask     = XLEN'(32'h0000_ffff);
        load_signed = 1'b1;
      end
      MEM_LOAD_HU: begin
        read_enable = 1'b1;
        wb_mask     = XLEN'(32'h0000_ffff);
      end
      MEM_LOAD_W: begin
        read_enable = 1'b1;
        wb_mask     = '1;
      end
      // width code: 0 byte, 1 half, 2 word
      MEM_STORE_B: begin
        write_enable = 1'b1;
        write_wstrb  = 2'd0;
      end
      MEM_STORE_H: begin
        write_enable = 1'b1;
        write_wstrb  = 2'd1;
      end
      MEM_STORE_W: begin
        write_enable = 1'b1;
        write_wstrb  = 2'd2;
      end
      default: begin
        write_enable = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* cpu/write_back.sv */
`timescale 1ns/10ps
`default_nettype none

module write_back (
  input  logic [cpu_pkg::XLEN-1:0] pc_prev,
  input  logic [cpu_pkg::XLEN-1:0] imm,
  input  logic [cpu_pkg::XLEN-1:0] alu_result,
  input  cpu_pkg::next_pc_sel      pc_sel,
  input  logic                     branch_taken,
  input  cpu_pkg::wb_sel           wb_sel,
  input  logic [4:0]               rd,
  input  logic [cpu_pkg::XLEN-1:0] read_data,
  input  logic [cpu_pkg::XLEN-1:0] wb_mask,
  input  logic                     load_signed,
  input  logic [1:0]               address_low,
  output logic [cpu_pkg::XLEN-1:0] pc_next,
  output logic [cpu_pkg::XLEN-1:0] reg_next,
  output logic                     wb_en
);
  import cpu_pkg::*;

  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] lane_data;
  logic [XLEN-1:0] load_value;
  logic            sign_bit;

  assign pc_plus4 = pc_prev + XLEN'(4);

  always_comb begin
    case (pc_sel)
      PC_BRANCH: pc_next = branch_taken ? pc_prev + imm : pc_plus4;
      // jal and jalr both arrive as an alu sum
      PC_JUMP:   pc_next = {alu_result[XLEN-1:1], 1'b0};
      default:   pc_next = pc_plus4;
    endcase
  end

  // move the addressed lane down to bit 0
  assign lane_data = read_data >> {address_low, 3'b000};

  // half mask has bit 15 set, byte mask does not
  assign sign_bit = wb_mask[15] ? lane_data[15] : lane_data[7];

  always_comb begin
    if (load_signed && sign_bit) begin
      load_value = (lane_data & wb_mask) | ~wb_mask;
    end else begin
      load_value = lane_data & wb_mask;
    end
  end

  always_comb begin
    case (wb_sel)
      WB_MEM:  reg_next = load_value;
      WB_PC4:  reg_next = pc_plus4;
      default: reg_next = alu_result;
    endcase
  end

  // decoder zeroes rd for instructions without a destination
  assign wb_en = (rd != 5'd0);

endmodule

`default_nettype wire

/* cpu/cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu #(
  parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
  input  logic                     clock,
  input  logic                     reset,
  output logic [cpu_pkg::XLEN-1:0] pc,
  input  logic [31:0]              instruction,
  output logic [cpu_pkg::XLEN-1:0] address,
  input  logic [cpu_pkg::XLEN-1:0] read_data,
  output logic                     read_enable,
  output logic [cpu_pkg::XLEN-1:0] write_data,
  output logic                     write_enable,
  output logic [1:0]               write_wstrb,
  output logic                     debug_ebreak,
  output logic [cpu_pkg::XLEN-1:0] debug_reg [0:31]
);
  import riscv_pkg::*;
  import cpu_pkg::*;

  logic [XLEN-1:0] reg_pc;
  logic [XLEN-1:0] regfile [0:31];

  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] alu_out;
  logic [XLEN-1:0] rs2_data;
  logic [4:0]      rd;
  logic            branch_taken;
  alu_cmd          alu_ops;
  mem_access_type  access_type;
  wb_sel           wb_select;
  next_pc_sel      pc_select;

  logic [XLEN-1:0] wb_mask;
  logic            load_signed;
  logic [XLEN-1:0] pc_next;
  logic [XLEN-1:0] reg_next;
  logic            wb_en;

  decoder i_decoder (
    .instruction  (instruction),
    .pc           (reg_pc),
    .regfile      (regfile),
    .op1          (op1),
    .op2          (op2),
    .alu_ops      (alu_ops),
    .access_type  (access_type),
    .wb_sel       (wb_select),
    .pc_sel       (pc_select),
    .branch_taken (branch_taken),
    .rd           (rd),
    .rs2_data     (rs2_data),
    .imm          (imm)
  );

  execute i_execute (
    .op1     (op1),
    .op2     (op2),
    .alu_ops (alu_ops),
    .alu_out (alu_out)
  );

  memory_access i_memory_access (
    .access_type  (access_type),
    .write_wstrb  (write_wstrb),
    .write_enable (write_enable),
    .read_enable  (read_enable),
    .wb_mask      (wb_mask),
    .load_signed  (load_signed)
  );

  write_back i_write_back (
    .pc_prev      (reg_pc),
    .imm          (imm),
    .alu_result   (alu_out),
    .pc_sel       (pc_select),
    .branch_taken (branch_taken),
    .wb_sel       (wb_select),
    .rd           (rd),
    .read_data    (read_data),
    .wb_mask      (wb_mask),
    .load_signed  (load_signed),
    .address_low  (alu_out[1:0]),
    .pc_next      (pc_next),
    .reg_next     (reg_next),
    .wb_en        (wb_en)
  );

  assign pc           = reg_pc;
  assign address      = alu_out;
  assign write_data   = rs2_data;
  assign debug_ebreak = (instruction == EBREAK);
  assign debug_reg    = regfile;

  // one instruction retires per edge; x0 is never written since wb_en needs rd != 0
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      reg_pc <= RESET_VECTOR;
      for (int i = 0; i < 32; i++) begin
        regfile[i] <= '0;
      end
    end else begin
      reg_pc <= pc_next;
      if (wb_en) begin
        regfile[rd] <= reg_next;
      end
    end
  end

endmodule

`default_nettype wire

/* src/data_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module data_memory #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                     clock,
  input  logic [cpu_pkg::XLEN-1:0] address,
  input  logic [cpu_pkg::XLEN-1:0] write_data,
  input  logic                     write_enable,
  input  logic [1:0]               write_wstrb,
  input  logic                     read_enable,
  output logic [cpu_pkg::XLEN-1:0] read_data
);
  import cpu_pkg::*;

  localparam int INDEX_BITS = $clog2(MEM_WORDS);

  logic [XLEN-1:0]       mem [0:MEM_WORDS-1];
  logic [INDEX_BITS-1:0] index;

  // word index, byte offset dropped
  assign index = address[INDEX_BITS+1:2];

  // whole aligned word, lane selection happens in the cpu
  assign read_data = read_enable ? mem[index] : '0;

  always_ff @(posedge clock) begin
    if (write_enable) begin
      case (write_wstrb)
        2'd0: begin
          mem[index][{address[1:0], 3'b000} +: 8] <= write_data[7:0];
        end
        2'd1: begin
          mem[index][{address[1], 4'b0000} +: 16] <= write_data[15:0];
        end
        default: begin
          mem[index] <= write_data;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/soc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_top #(
  parameter logic [31:0] RESET_VECTOR = 32'h0000_0000,
  parameter int          MEM_WORDS    = 1024
) (
  input  logic                     clock,
  input  logic                     reset,
  output logic [cpu_pkg::XLEN-1:0] pc,
  input  logic [31:0]              instruction,
  output logic                     debug_ebreak,
  output logic [cpu_pkg::XLEN-1:0] debug_reg [0:31]
);
  import cpu_pkg::*;

  logic [XLEN-1:0] address;
  logic [XLEN-1:0] read_data;
  logic [XLEN-1:0] write_data;
  logic            read_enable;
  logic            write_enable;
  logic [1:0]      write_wstrb;

  cpu #(
    .RESET_VECTOR (RESET_VECTOR)
  ) i_cpu (
    .clock        (clock),
    .reset        (reset),
    .pc           (pc),
    .instruction  (instruction),
    .address      (address),
    .read_data    (read_data),
    .read_enable  (read_enable),
    .write_data   (write_data),
    .write_enable (write_enable),
    .write_wstrb  (write_wstrb),
    .debug_ebreak (debug_ebreak),
    .debug_reg    (debug_reg)
  );

  data_memory #(
    .MEM_WORDS (MEM_WORDS)
  ) i_data_memory (
    .clock        (clock),
    .address      (address),
    .write_data   (write_data),
    .write_enable (write_enable),
    .write_wstrb  (write_wstrb),
    .read_enable  (read_enable),
    .read_data    (read_data)
  );

endmodule

`default_nettype wire

/* sim/soc_top_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_top_sva #(
  parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
  input wire logic        clock,
  input wire logic        reset,
  input wire logic [31:0] pc,
  input wire logic        read_enable,
  input wire logic        write_enable,
  input wire logic [31:0] debug_reg0
);

  pc_aligned: assert property (@(posedge clock) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  // a single instruction cannot both load and store
  enables_exclusive: assert property (@(posedge clock) !(read_enable && write_enable))
    else $error("read and write enables are both high");

  pc_after_reset: assert property (@(posedge clock) $fell(reset) |-> pc == RESET_VECTOR)
    else $error("pc does not equal the reset vector after reset");

  x0_zero: assert property (@(posedge clock) debug_reg0 == 32'h0)
    else $error("register x0 is not zero");

endmodule

bind soc_top soc_top_sva #(
  .RESET_VECTOR (RESET_VECTOR)
) i_soc_top_sva (
  .clock        (clock),
  .reset        (reset),
  .pc           (pc),
  .read_enable  (read_enable),
  .write_enable (write_enable),
  .debug_reg0   (debug_reg[0])
);

`default_nettype wire

/* sim/tb_soc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_soc_top;
  import riscv_pkg::*;

  localparam logic [31:0] RESET_VECTOR   = 32'h0000_0000;
  localparam int          MEM_WORDS      = 1024;
  localparam int          PROG_WORDS     = 128;
  localparam int          TIMEOUT_CYCLES = 1000;

  logic        clock;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] instruction;
  logic        debug_ebreak;
  logic [31:0] debug_reg [0:31];

  logic [31:0] program_words [0:PROG_WORDS-1];
  logic [31:0] exp_regs [0:31];
  logic        fetch_enable;
  int          prog_len;
  int          ebreak_index;
  int          error_count;
  int          check_count;

  soc_top #(
    .RESET_VECTOR (RESET_VECTOR),
    .MEM_WORDS    (MEM_WORDS)
  ) i_dut (
    .clock        (clock),
    .reset        (reset),
    .pc           (pc),
    .instruction  (instruction),
    .debug_ebreak (debug_ebreak),
    .debug_reg    (debug_reg)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - RESET_VECTOR) >> 2;
    if (idx < PROG_WORDS) begin
      return program_words[idx];
    end
    return NOP;
  endfunction

  // instruction memory with the word following pc right after each rising edge
  always @(pc or fetch_enable) begin
    if (fetch_enable) begin
      instruction <= fetch_word(pc);
    end else begin
      instruction <= NOP;
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input int offset);
    logic [12:0] imm;
    imm = offset[12:0];
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input int offset);
    logic [20:0] imm;
    imm = offset[20:0];
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  task automatic begin_program();
    for (int i = 0; i < PROG_WORDS; i++) begin
      program_words[i] = NOP;
    end
    for (int i = 0; i < 32; i++) begin
      exp_regs[i] = 32'h0;
    end
    prog_len = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    program_words[prog_len] = word;
    prog_len++;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = (value + 32'h800) >> 12;
    emit({upper[19:0], rd, OPC_LUI});
    emit(enc_i(OPC_OP_IMM, rd, F3_ADD, rd, value[11:0]));
  endtask

  task automatic end_program();
    ebreak_index = prog_len;
    emit(EBREAK);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
    end
  endtask

  task automatic compare_registers();
    for (int i = 0; i < 32; i++) begin
      check_value($sformatf("x%0d", i), debug_reg[i], exp_regs[i]);
    end
  endtask

  // holds reset for 10 cycles with NOP driven
  task automatic apply_reset(input logic start_fetch);
    @(posedge clock);
    reset        <= 1'b1;
    fetch_enable <= 1'b0;
    repeat (9) @(posedge clock);
    @(negedge clock);
    check_value("pc", pc, RESET_VECTOR);
    check_value("debug_ebreak", {31'b0, debug_ebreak}, 32'h0);
    @(posedge clock);
    reset        <= 1'b0;
    fetch_enable <= start_fetch;
  endtask

  task automatic run_program();
    int  cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    apply_reset(1'b1);
    while (!done) begin
      @(negedge clock);
      cycles++;
      if (debug_ebreak) begin
        done = 1'b1;
        check_value("pc", pc, RESET_VECTOR + 32'(4 * ebreak_index));
        compare_registers();
      end else if (cycles >= TIMEOUT_CYCLES) begin
        done = 1'b1;
        error_count++;
        $display("Timeout at %0t: debug_ebreak never rose", $time);
      end
    end
    @(posedge clock);
    fetch_enable <= 1'b0;
  endtask

  task automatic test_reset_state();
    apply_reset(1'b0);
    for (int k = 0; k < 5; k++) begin
      @(negedge clock);
      check_value("pc", pc, RESET_VECTOR + 32'(4 * k));
    end
    for (int i = 0; i < 32; i++) begin
      exp_regs[i] = 32'h0;
    end
    compare_registers();
  endtask

  task automatic test_arithmetic();
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    logic [31:0] ims;
    logic [4:0]  sh;
    a   = $urandom | 32'h8000_0000;
    b   = $urandom;
    imm = 12'($urandom);
    sh  = 5'($urandom);
    ims = {{20{imm[11]}}, imm};
    begin_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    emit(enc_r(7'd0, 5'd2, 5'd1, F3_ADD, 5'd3));
    emit(enc_r(F7_ALT, 5'd2, 5'd1, F3_ADD, 5'd4));
    emit(enc_r(7'd0, 5'd2, 5'd1, F3_SLL, 5'd5));
    emit(enc_r(7'd0, 5'd2, 5'd1, F3_SLT, 5'd6));
    emit(enc_r(7'd0, 5'd2, 5'd1, F3_SLTU, 5'd7));
    emit(enc_r(7'd0, 5'd2, 5'd1, F3_XOR, 5'd8));
    emit(enc_r(7'd0, 5'd2, 5'd1, F3_SRL, 5'd9));
    emit(enc_r(F7_ALT, 5'd2, 5'd1, F3_SRL, 5'd10));
    emit(enc_r(7'd0, 5'd2, 5'd1, F3_OR, 5'd11));
    emit(enc_r(7'd0, 5'd2, 5'd1, F3_AND, 5'd12));
    emit(enc_i(OPC_OP_IMM, 5'd13, F3_ADD, 5'd1, imm));
    emit(enc_i(OPC_OP_IMM, 5'd14, F3_SLT, 5'd1, imm));
    emit(enc_i(OPC_OP_IMM, 5'd15, F3_SLTU, 5'd1, imm));
    emit(enc_i(OPC_OP_IMM, 5'd16, F3_XOR, 5'd1, imm));
    emit(enc_i(OPC_OP_IMM, 5'd17, F3_OR, 5'd1, imm));
    emit(enc_i(OPC_OP_IMM, 5'd18, F3_AND, 5'd1, imm));
    emit(enc_i(OPC_OP_IMM, 5'd19, F3_SLL, 5'd1, {7'd0, sh}));
    emit(enc_i(OPC_OP_IMM, 5'd20, F3_SRL, 5'd1, {7'd0, sh}));
    emit(enc_i(OPC_OP_IMM, 5'd21, F3_SRL, 5'd1, {F7_ALT, sh}));
    exp_regs[22] = RESET_VECTOR + 32'(4 * prog_len) + {imm, 20'h0};
    emit({imm, 8'h00, 5'd22, OPC_AUIPC});
    end_program();
    exp_regs[1]  = a;
    exp_regs[2]  = b;
    exp_regs[3]  = a + b;
    exp_regs[4]  = a - b;
    exp_regs[5]  = a << b[4:0];
    exp_regs[6]  = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    exp_regs[7]  = (a < b) ? 32'd1 : 32'd0;
    exp_regs[8]  = a ^ b;
    exp_regs[9]  = a >> b[4:0];
    exp_regs[10] = $signed(a) >>> b[4:0];
    exp_regs[11] = a | b;
    exp_regs[12] = a & b;
    exp_regs[13] = a + ims;
    exp_regs[14] = ($signed(a) < $signed(ims)) ? 32'd1 : 32'd0;
    exp_regs[15] = (a < ims) ? 32'd1 : 32'd0;
    exp_regs[16] = a ^ ims;
    exp_regs[17] = a | ims;
    exp_regs[18] = a & ims;
    exp_regs[19] = a << sh;
    exp_regs[20] = a >> sh;
    exp_regs[21] = $signed(a) >>> sh;
    run_program();
  endtask

  task automatic test_loads_stores();
    begin_program();
    load_const(5'd1, 32'h0000_0100);
    load_const(5'd2, 32'h89AB_CDEF);
    load_const(5'd3, 32'h0000_00A5);
    load_const(5'd4, 32'h1234_8765);
    emit(enc_s(F3_W, 5'd2, 5'd1, 12'd0));
    emit(enc_s(F3_W, 5'd0, 5'd1, 12'd4));
    emit(enc_s(F3_W, 5'd0, 5'd1, 12'd8));
    emit(enc_s(F3_B, 5'd3, 5'd1, 12'd5));
    emit(enc_s(F3_H, 5'd4, 5'd1, 12'd10));
    emit(enc_i(OPC_LOAD, 5'd10, F3_W, 5'd1, 12'd0));
    emit(enc_i(OPC_LOAD, 5'd11, F3_B, 5'd1, 12'd1));
    emit(enc_i(OPC_LOAD, 5'd12, F3_BU, 5'd1, 12'd3));
    emit(enc_i(OPC_LOAD, 5'd13, F3_H, 5'd1, 12'd2));
    emit(enc_i(OPC_LOAD, 5'd14, F3_HU, 5'd1, 12'd0));
    emit(enc_i(OPC_LOAD, 5'd15, F3_W, 5'd1, 12'd4));
    emit(enc_i(OPC_LOAD, 5'd16, F3_B, 5'd1, 12'd5));
    emit(enc_i(OPC_LOAD, 5'd17, F3_W, 5'd1, 12'd8));
    emit(enc_i(OPC_LOAD, 5'd18, F3_H, 5'd1, 12'd10));
    emit(enc_i(OPC_LOAD, 5'd19, F3_HU, 5'd1, 12'd10));
    emit(enc_i(OPC_LOAD, 5'd20, F3_BU, 5'd1, 12'd0));
    // byte into lane 2 of an already written word
    emit(enc_s(F3_B, 5'd3, 5'd1, 12'd2));
    emit(enc_i(OPC_LOAD, 5'd21, F3_W, 5'd1, 12'd0));
    end_program();
    exp_regs[1]  = 32'h0000_0100;
    exp_regs[2]  = 32'h89AB_CDEF;
    exp_regs[3]  = 32'h0000_00A5;
    exp_regs[4]  = 32'h1234_8765;
    exp_regs[10] = 32'h89AB_CDEF;
    exp_regs[11] = 32'hFFFF_FFCD;
    exp_regs[12] = 32'h0000_0089;
    exp_regs[13] = 32'hFFFF_89AB;
    exp_regs[14] = 32'h0000_CDEF;
    exp_regs[15] = 32'h0000_A500;
    exp_regs[16] = 32'hFFFF_FFA5;
    exp_regs[17] = 32'h8765_0000;
    exp_regs[18] = 32'hFFFF_8765;
    exp_regs[19] = 32'h0000_8765;
    exp_regs[20] = 32'h0000_00EF;
    exp_regs[21] = 32'h89A5_CDEF;
    run_program();
  endtask

  task automatic test_control_flow();
    int target;
    begin_program();
    emit(enc_i(OPC_OP_IMM, 5'd2, F3_ADD, 5'd0, 12'd5));
    // counted loop where x1 counts up to x2
    emit(enc_i(OPC_OP_IMM, 5'd1, F3_ADD, 5'd1, 12'd1));
    emit(enc_i(OPC_OP_IMM, 5'd3, F3_ADD, 5'd3, 12'd2));
    emit(enc_b(F3_BNE, 5'd1, 5'd2, -8));
    exp_regs[5] = RESET_VECTOR + 32'(4 * prog_len + 4);
    emit(enc_j(5'd5, 8));
    emit(enc_i(OPC_OP_IMM, 5'd6, F3_ADD, 5'd0, 12'd99));
    emit(enc_i(OPC_OP_IMM, 5'd7, F3_ADD, 5'd0, 12'd1));
    target = 4 * (prog_len + 3) + int'(RESET_VECTOR);
    emit(enc_i(OPC_OP_IMM, 5'd8, F3_ADD, 5'd0, 12'(target)));
    exp_regs[9] = RESET_VECTOR + 32'(4 * prog_len + 4);
    // offset 1 checks that bit 0 of the target is cleared
    emit(enc_i(OPC_JALR, 5'd9, 3'd0, 5'd8, 12'd1));
    emit(enc_i(OPC_OP_IMM, 5'd10, F3_ADD, 5'd0, 12'd77));
    emit(enc_i(OPC_OP_IMM, 5'd11, F3_ADD, 5'd0, 12'd1));
    emit(enc_i(OPC_OP_IMM, 5'd12, F3_ADD, 5'd0, 12'd2));
    emit(enc_i(OPC_OP_IMM, 5'd13, F3_ADD, 5'd0, 12'hFFF));
    emit(enc_b(F3_BEQ, 5'd11, 5'd12, 8));
    emit(enc_i(OPC_OP_IMM, 5'd14, F3_ADD, 5'd14, 12'd1));
    emit(enc_b(F3_BNE, 5'd11, 5'd11, 8));
    emit(enc_i(OPC_OP_IMM, 5'd14, F3_ADD, 5'd14, 12'd1));
    emit(enc_b(F3_BLT, 5'd12, 5'd11, 8));
    emit(enc_i(OPC_OP_IMM, 5'd14, F3_ADD, 5'd14, 12'd1));
    emit(enc_b(F3_BGE, 5'd11, 5'd12, 8));
    emit(enc_i(OPC_OP_IMM, 5'd14, F3_ADD, 5'd14, 12'd1));
    emit(enc_b(F3_BLTU, 5'd13, 5'd11, 8));
    emit(enc_i(OPC_OP_IMM, 5'd14, F3_ADD, 5'd14, 12'd1));
    emit(enc_b(F3_BGEU, 5'd11, 5'd13, 8));
    emit(enc_i(OPC_OP_IMM, 5'd14, F3_ADD, 5'd14, 12'd1));
    end_program();
    exp_regs[1]  = 32'd5;
    exp_regs[2]  = 32'd5;
    exp_regs[3]  = 32'd10;
    exp_regs[7]  = 32'd1;
    exp_regs[8]  = 32'(target);
    exp_regs[11] = 32'd1;
    exp_regs[12] = 32'd2;
    exp_regs[13] = 32'hFFFF_FFFF;
    exp_regs[14] = 32'd6;
    run_program();
  endtask

  task automatic test_x0_and_ebreak();
    begin_program();
    emit(enc_i(OPC_OP_IMM, 5'd1, F3_ADD, 5'd0, 12'd3));
    emit(enc_i(OPC_OP_IMM, 5'd0, F3_ADD, 5'd0, 12'd5));
    emit({20'hFFFFF, 5'd0, OPC_LUI});
    emit(enc_r(7'd0, 5'd1, 5'd1, F3_ADD, 5'd0));
    emit(enc_i(OPC_OP_IMM, 5'd2, F3_ADD, 5'd0, 12'd7));
    emit(NOP);
    emit(NOP);
    end_program();
    exp_regs[1] = 32'd3;
    exp_regs[2] = 32'd7;
    run_program();
  endtask

  initial begin
    void'($urandom(32'h5386));
    reset        = 1'b1;
    instruction  = NOP;
    fetch_enable = 1'b0;
    error_count  = 0;
    check_count  = 0;
    test_reset_state();
    test_arithmetic();
    test_loads_stores();
    test_control_flow();
    test_x0_and_ebreak();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* soc_top.f */
common/riscv_pkg.sv
common/cpu_pkg.sv
cpu/decoder.sv
cpu/execute.sv
cpu/memory_access.sv
cpu/write_back.sv
cpu/cpu.sv
src/data_memory.sv
src/soc_top.sv
sim/soc_top_sva.sv
sim/tb_soc_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_soc_top
FILELIST  ?= soc_top.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --assert --timing -j 0
PASS_TEXT ?= TESTBENCH PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR)
